// File: hdl/conv_pkg.sv
package conv_pkg;

    localparam int pixel_w  = 8;
    localparam int weight_w = 8;
    localparam int acc_w    = 20;
    localparam int addr_w   = 12;

    typedef logic [pixel_w-1:0]         pixel_t;
    typedef logic signed [weight_w-1:0] weight_t;
    // wide enough for four products of 255 * -128
    typedef logic signed [acc_w-1:0]    acc_t;
    typedef logic [addr_w-1:0]          pix_addr_t;

    // kernel weights, row then column
    typedef struct packed {
        weight_t w00;
        weight_t w01;
        weight_t w10;
        weight_t w11;
    } kernel_t;

    typedef struct packed {
        pixel_t p00;
        pixel_t p01;
        pixel_t p10;
        pixel_t p11;
    } window_t;

    // index is the raster position in the output image
    typedef struct packed {
        pix_addr_t index;
        acc_t      value;
    } result_t;

    typedef enum logic [3:0] {
        st_idle            = 4'd0,
        st_addr            = 4'd1,
        st_load            = 4'd2,
        st_mac0            = 4'd3,
        st_mac1            = 4'd4,
        st_store           = 4'd5,
        st_update_counters = 4'd6,
        st_check_done      = 4'd7
    } conv_state_e;

endpackage

// File: hdl/conv_control.sv
`timescale 1ns/100ps

module conv_control
(
    input  logic clk,
    input  logic rst_n,
    input  logic conv,
    input  logic done,
    input  logic load_done,
    output logic addr_gen_pulse,
    output logic load,
    output logic add,
    output logic counter_enable,
    output logic flush_acc,
    output logic store,
    output logic busy
);
    import conv_pkg::*;

    conv_state_e state;
    conv_state_e next_state;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        // strobes default low, each state raises its own
        addr_gen_pulse = 1'b0;
        flush_acc      = 1'b0;
        load           = 1'b0;
        add            = 1'b0;
        store          = 1'b0;
        counter_enable = 1'b0;
        next_state     = state;

        case (state)
            st_idle:
            begin
                next_state = conv ? st_addr : st_idle;
            end
            st_addr:
            begin
                addr_gen_pulse = 1'b1;
                flush_acc      = 1'b1;
                next_state     = st_load;
            end
            st_load:
            begin
                // held for the whole fetch of four pixels
                load       = 1'b1;
                next_state = load_done ? st_mac0 : st_load;
            end
            st_mac0:
            begin
                add        = 1'b1;
                next_state = st_mac1;
            end
            st_mac1:
            begin
                add        = 1'b1;
                next_state = st_store;
            end
            st_store:
            begin
                store      = 1'b1;
                next_state = st_update_counters;
            end
            st_update_counters:
            begin
                counter_enable = 1'b1;
                next_state     = st_check_done;
            end
            st_check_done:
            begin
                next_state = done ? st_idle : st_addr;
            end
            default:
            begin
                next_state = st_idle;
            end
        endcase
    end

    assign busy = (state != st_idle);

endmodule

// File: hdl/conv_addr_gen.sv
`timescale 1ns/100ps

module conv_addr_gen
#(
    parameter int img_w = 8,
    parameter int img_h = 8
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                addr_gen_pulse,
    input  logic                counter_enable,
    output conv_pkg::pix_addr_t base_addr,
    output conv_pkg::pix_addr_t out_index,
    output logic                done
);
    import conv_pkg::*;

    pix_addr_t row;
    pix_addr_t col;
    logic      last_col;
    logic      last_row;

    // valid region stops one short of each image edge
    assign last_col = (col == pix_addr_t'(img_w - 2));
    assign last_row = (row == pix_addr_t'(img_h - 2));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            row       <= '0;
            col       <= '0;
            out_index <= '0;
            done      <= 1'b0;
        end
        else
        begin
            if (addr_gen_pulse)
                done <= 1'b0;
            if (counter_enable)
            begin
                if (last_col && last_row)
                begin
                    // frame complete, rewind for the next one
                    row       <= '0;
                    col       <= '0;
                    out_index <= '0;
                    done      <= 1'b1;
                end
                else if (last_col)
                begin
                    row       <= row + 1'b1;
                    col       <= '0;
                    out_index <= out_index + 1'b1;
                end
                else
                begin
                    col       <= col + 1'b1;
                    out_index <= out_index + 1'b1;
                end
            end
        end
    end

    // top-left pixel of the current window
    always_ff @(posedge clk)
    begin
        if (addr_gen_pulse)
            base_addr <= pix_addr_t'(row * img_w + col);
    end

endmodule

// File: hdl/conv_window_loader.sv
`timescale 1ns/100ps

module conv_window_loader
#(
    parameter int img_w = 8
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,
    input  conv_pkg::pix_addr_t base_addr,
    input  conv_pkg::pixel_t    pix_data,
    output logic                pix_rd,
    output conv_pkg::pix_addr_t pix_addr,
    output conv_pkg::window_t   window,
    output logic                load_done
);
    import conv_pkg::*;

    localparam logic [2:0] last_tap = 3'd4;

    logic [2:0] tap;
    pix_addr_t  offset;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            tap <= '0;
        else if (!load)
            tap <= '0;
        else if (tap != last_tap)
            tap <= tap + 1'b1;
    end

    // window taps in raster order
    always_comb
    begin
        case (tap)
            3'd0:    offset = '0;
            3'd1:    offset = pix_addr_t'(1);
            3'd2:    offset = pix_addr_t'(img_w);
            default: offset = pix_addr_t'(img_w + 1);
        endcase
    end

    assign pix_addr  = base_addr + offset;
    assign pix_rd    = load && (tap != last_tap);
    assign load_done = load && (tap == last_tap);

    // data returns one cycle after its read, so tap n captures read n-1
    always_ff @(posedge clk)
    begin
        if (load && (tap != 3'd0))
        begin
            case (tap)
                3'd1:    window.p00 <= pix_data;
                3'd2:    window.p01 <= pix_data;
                3'd3:    window.p10 <= pix_data;
                default: window.p11 <= pix_data;
            endcase
        end
    end

endmodule

// File: hdl/conv_mac.sv
`timescale 1ns/100ps

module conv_mac
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush_acc,
    input  logic              add,
    input  conv_pkg::window_t window,
    input  conv_pkg::kernel_t kernel,
    output conv_pkg::acc_t    acc
);
    import conv_pkg::*;

    logic    pair_sel;
    pixel_t  pix_a;
    pixel_t  pix_b;
    weight_t w_a;
    weight_t w_b;
    acc_t    prod_a;
    acc_t    prod_b;

    // pair 0 is the top row of the window, pair 1 the bottom row
    assign pix_a = pair_sel ? window.p10 : window.p00;
    assign pix_b = pair_sel ? window.p11 : window.p01;
    assign w_a   = pair_sel ? kernel.w10 : kernel.w00;
    assign w_b   = pair_sel ? kernel.w11 : kernel.w01;

    // pixels zero-extended, weights sign-extended
    assign prod_a = acc_t'({1'b0, pix_a}) * acc_t'(w_a);
    assign prod_b = acc_t'({1'b0, pix_b}) * acc_t'(w_b);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pair_sel <= 1'b0;
        else if (flush_acc)
            pair_sel <= 1'b0;
        else if (add)
            pair_sel <= ~pair_sel;
    end

    always_ff @(posedge clk)
    begin
        if (flush_acc)
            acc <= '0;
        else if (add)
            acc <= acc + prod_a + prod_b;
    end

endmodule

// File: hdl/conv_top.sv
`timescale 1ns/100ps

module conv_top
#(
    parameter int img_w = 8,
    parameter int img_h = 8
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                conv,
    input  conv_pkg::kernel_t   kernel,
    input  conv_pkg::pixel_t    pix_data,
    output logic                pix_rd,
    output conv_pkg::pix_addr_t pix_addr,
    output logic                busy,
    output logic                result_valid,
    output conv_pkg::result_t   result
);
    import conv_pkg::*;

    logic      addr_gen_pulse;
    logic      load;
    logic      add;
    logic      counter_enable;
    logic      flush_acc;
    logic      store;
    logic      load_done;
    logic      done;
    pix_addr_t base_addr;
    pix_addr_t out_index;
    window_t   window;
    acc_t      acc;

    conv_control u_control
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .conv           (conv),
        .done           (done),
        .load_done      (load_done),
        .addr_gen_pulse (addr_gen_pulse),
        .load           (load),
        .add            (add),
        .counter_enable (counter_enable),
        .flush_acc      (flush_acc),
        .store          (store),
        .busy           (busy)
    );

    conv_addr_gen #(.img_w(img_w), .img_h(img_h)) u_addr_gen
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .addr_gen_pulse (addr_gen_pulse),
        .counter_enable (counter_enable),
        .base_addr      (base_addr),
        .out_index      (out_index),
        .done           (done)
    );

    conv_window_loader #(.img_w(img_w)) u_loader
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .base_addr (base_addr),
        .pix_data  (pix_data),
        .pix_rd    (pix_rd),
        .pix_addr  (pix_addr),
        .window    (window),
        .load_done (load_done)
    );

    conv_mac u_mac
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush_acc (flush_acc),
        .add       (add),
        .window    (window),
        .kernel    (kernel),
        .acc       (acc)
    );

    // out_index still names the current position during store
    assign result_valid = store;
    assign result.index = out_index;
    assign result.value = acc;

endmodule

// File: tb/conv_assert.sv
`timescale 1ns/100ps

module conv_assert
#(
    parameter int img_w = 8,
    parameter int img_h = 8
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  conv,
    input  conv_pkg::conv_state_e state,
    input  logic                  busy,
    input  logic                  result_valid,
    input  logic                  pix_rd,
    input  conv_pkg::pix_addr_t   pix_addr
);
    import conv_pkg::*;

    // results only leave during a frame
    a_result_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> busy)
        else $error("result strobe while the engine is idle");

    a_read_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        pix_rd |-> (int'(pix_addr) < img_w * img_h))
        else $error("pixel read outside the image");

    // a start sampled in idle moves the FSM to addr
    a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_idle) && conv |=> busy)
        else $error("busy did not rise after a start in idle");

endmodule

// File: tb/conv_checker.sv
`timescale 1ns/100ps

module conv_checker
#(
    parameter int img_w = 8,
    parameter int img_h = 8
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                conv,
    input  logic                busy,
    input  logic                pix_rd,
    input  conv_pkg::pix_addr_t pix_addr,
    input  logic                result_valid,
    input  conv_pkg::result_t   result,
    input  conv_pkg::kernel_t   kernel,
    input  conv_pkg::pixel_t    image [img_w*img_h],
    output int                  value_errors,
    output int                  protocol_errors,
    output int                  results_seen
);
    import conv_pkg::*;

    localparam int out_w        = img_w - 1;
    localparam int positions    = (img_h - 1) * out_w;
    localparam int frame_cycles = 11 * positions;

    int   value_err_count = 0;
    int   protocol_err_count = 0;
    int   result_count = 0;
    int   expect_index = 0;
    int   busy_cycles = 0;
    int   expected;
    logic busy_q = 1'b0;
    logic start_pending = 1'b0;

    assign value_errors    = value_err_count;
    assign protocol_errors = protocol_err_count;
    assign results_seen    = result_count;

    // sum of the four products of a 2x2 window, from the image itself
    function automatic int window_sum(input int index);
        int base;
        base = (index / out_w) * img_w + (index % out_w);
        return int'(image[base]) * int'($signed(kernel.w00))
             + int'(image[base + 1]) * int'($signed(kernel.w01))
             + int'(image[base + img_w]) * int'($signed(kernel.w10))
             + int'(image[base + img_w + 1]) * int'($signed(kernel.w11));
    endfunction

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            if (busy || result_valid || pix_rd)
            begin
                $display("engine not quiet during reset at %0t", $time);
                protocol_err_count++;
            end
            busy_q        = 1'b0;
            start_pending = 1'b0;
        end
        else
        begin
            if (start_pending && !busy)
            begin
                $display("busy did not rise after a start at %0t", $time);
                protocol_err_count++;
            end
            start_pending = !busy && conv;

            if (pix_rd && (int'(pix_addr) >= img_w * img_h))
            begin
                $display("pixel read at %0d is outside the image at %0t", pix_addr, $time);
                protocol_err_count++;
            end

            if (busy && !busy_q)
            begin
                expect_index = 0;
                busy_cycles  = 0;
            end
            if (busy)
                busy_cycles++;

            if (result_valid)
            begin
                result_count++;
                if (!busy)
                begin
                    $display("result strobe while idle at %0t", $time);
                    protocol_err_count++;
                end
                if (int'(result.index) != expect_index)
                begin
                    $display("[FAIL] %0t: result index %0d, expected %0d",
                             $time, result.index, expect_index);
                    value_err_count++;
                end
                if (expect_index < positions)
                begin
                    expected = window_sum(expect_index);
                    if (int'($signed(result.value)) != expected)
                    begin
                        $display("[FAIL] %0t: result %0d value %0d, expected %0d",
                                 $time, expect_index, $signed(result.value), expected);
                        value_err_count++;
                    end
                end
                expect_index++;
            end

            // frame closes when busy falls
            if (!busy && busy_q)
            begin
                if (expect_index != positions)
                begin
                    $display("[FAIL] %0t: frame gave %0d results, expected %0d",
                             $time, expect_index, positions);
                    value_err_count++;
                end
                if (busy_cycles != frame_cycles)
                begin
                    $display("[FAIL] %0t: frame busy for %0d cycles, expected %0d",
                             $time, busy_cycles, frame_cycles);
                    value_err_count++;
                end
            end
            busy_q = busy;
        end
    end

endmodule

// File: tb/conv_tb.sv
`timescale 1ns/100ps

module conv_tb;
    import conv_pkg::*;

    localparam int img_w       = 6;
    localparam int img_h       = 5;
    localparam int pixels      = img_w * img_h;
    localparam int frame_limit = 11 * (img_h - 1) * (img_w - 1) + 40;
    localparam int n_rows      = 8;

    localparam logic [1:0] img_random = 2'd0;
    localparam logic [1:0] img_full   = 2'd1;
    localparam logic [1:0] img_zero   = 2'd2;

    typedef struct packed {
        kernel_t    kernel;
        logic [1:0] mode;
        logic       extra_conv;
    } stim_t;

    logic        clk;
    logic        rst_n;
    logic        conv;
    kernel_t     kernel;
    pixel_t      pix_data = '0;
    logic        pix_rd;
    pix_addr_t   pix_addr;
    logic        busy;
    logic        result_valid;
    result_t     result;
    pixel_t      image [pixels];
    stim_t       stim_rows [n_rows];
    logic [15:0] lfsr;
    logic        rd_q;
    pix_addr_t   addr_q;
    int          timeouts;
    int          value_errors;
    int          protocol_errors;
    int          results_seen;

    conv_top #(.img_w(img_w), .img_h(img_h)) uut
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .conv         (conv),
        .kernel       (kernel),
        .pix_data     (pix_data),
        .pix_rd       (pix_rd),
        .pix_addr     (pix_addr),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    conv_checker #(.img_w(img_w), .img_h(img_h)) u_checker
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .conv            (conv),
        .busy            (busy),
        .pix_rd          (pix_rd),
        .pix_addr        (pix_addr),
        .result_valid    (result_valid),
        .result          (result),
        .kernel          (kernel),
        .image           (image),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .results_seen    (results_seen)
    );

    bind conv_top conv_assert #(.img_w(img_w), .img_h(img_h)) u_assert
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .conv         (conv),
        .state        (u_control.state),
        .busy         (busy),
        .result_valid (result_valid),
        .pix_rd       (pix_rd),
        .pix_addr     (pix_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // pixel memory answers one cycle after the read
    always @(posedge clk)
    begin
        rd_q   = pix_rd;
        addr_q = pix_addr;
        #1;
        if (rd_q && (int'(addr_q) < pixels))
            pix_data = image[addr_q];
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hb400;
        else
            return state >> 1;
    endfunction

    function automatic stim_t make_row(input int w00, input int w01, input int w10,
                                       input int w11, input logic [1:0] mode,
                                       input logic extra_conv);
        stim_t row;
        row.kernel.w00  = weight_t'(w00);
        row.kernel.w01  = weight_t'(w01);
        row.kernel.w10  = weight_t'(w10);
        row.kernel.w11  = weight_t'(w11);
        row.mode        = mode;
        row.extra_conv  = extra_conv;
        return row;
    endfunction

    task automatic fill_image(input logic [1:0] mode);
        pixel_t value;
        for (int i = 0; i < pixels; i++)
        begin
            value = '0;
            if (mode == img_full)
                value = 8'hff;
            else if (mode == img_random)
            begin
                // one LFSR step per bit
                for (int b = 0; b < 8; b++)
                begin
                    value[b] = lfsr[0];
                    lfsr     = lfsr_step(lfsr);
                end
            end
            image[i] = value;
        end
    endtask

    // start a frame and pull reset part way through it
    task automatic abort_frame(input stim_t row);
        fill_image(row.mode);
        @(posedge clk);
        #1;
        kernel = row.kernel;
        conv   = 1'b1;
        @(posedge clk);
        #1;
        conv = 1'b0;
        repeat (30) @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic run_frame(input stim_t row);
        int wait_count;
        fill_image(row.mode);
        @(posedge clk);
        #1;
        kernel = row.kernel;
        conv   = 1'b1;
        @(posedge clk);
        #1;
        conv       = 1'b0;
        wait_count = 0;
        while (!busy && wait_count < 5)
        begin
            @(posedge clk);
            #1;
            wait_count++;
        end
        if (!busy)
        begin
            $display("timeout: busy never rose after the start at %0t", $time);
            timeouts++;
        end
        else
        begin
            wait_count = 0;
            while (busy && wait_count < frame_limit)
            begin
                @(posedge clk);
                #1;
                wait_count++;
                // stray start in the middle of the frame
                conv = row.extra_conv && (wait_count == 40);
            end
            conv = 1'b0;
            if (busy)
            begin
                $display("timeout: busy still high after %0d cycles at %0t",
                         frame_limit, $time);
                timeouts++;
            end
        end
    endtask

    initial
    begin
        rst_n    = 1'b0;
        conv     = 1'b0;
        kernel   = '0;
        lfsr     = 16'd9978;
        timeouts = 0;

        // kernel weights, image mode, extra start
        stim_rows[0] = make_row(1, 2, 3, 4, img_random, 1'b0);
        stim_rows[1] = make_row(-1, 1, -2, 2, img_random, 1'b1);
        stim_rows[2] = make_row(127, 127, 127, 127, img_full, 1'b0);
        stim_rows[3] = make_row(-128, -128, -128, -128, img_full, 1'b1);
        stim_rows[4] = make_row(-128, 127, -128, 127, img_zero, 1'b0);
        stim_rows[5] = make_row(127, -128, -1, 64, img_random, 1'b0);
        stim_rows[6] = make_row(0, 0, 0, 1, img_random, 1'b1);
        stim_rows[7] = make_row(-128, 127, 127, -128, img_full, 1'b0);

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset in mid-frame drops the engine to idle, the table then starts fresh
        abort_frame(stim_rows[0]);

        for (int r = 0; r < n_rows; r++)
        begin
            if (timeouts == 0)
                run_frame(stim_rows[r]);
        end

        repeat (2) @(posedge clk);
        $display("results=%0d value errors=%0d protocol errors=%0d timeouts=%0d",
                 results_seen, value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: filelist.f
hdl/conv_pkg.sv
hdl/conv_control.sv
hdl/conv_addr_gen.sv
hdl/conv_window_loader.sv
hdl/conv_mac.sv
hdl/conv_top.sv
tb/conv_assert.sv
tb/conv_checker.sv
tb/conv_tb.sv

// File: run.sh
#!/bin/sh
# build and run the convolution engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module conv_tb \
    -f filelist.f --Mdir "$build_dir" -o conv_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/conv_sim" +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
